// File: rtl/audio_pkg.sv
/* Samples are signed two's complement, one per channel.
   A frame carries left in the upper half and right in the lower half. */
package audio_pkg;

    // Bits per channel sample
    localparam int SAMPLE_W = 24;

    // Stereo frame as stored in the FIFO
    localparam int FRAME_W = 2 * SAMPLE_W;

    // Bit-clock periods per I2S channel slot
    localparam int SLOT_BITS = 32;

    function automatic logic [FRAME_W-1:0] pack_frame(
        input logic [SAMPLE_W-1:0] left,
        input logic [SAMPLE_W-1:0] right
    );
        return {left, right};
    endfunction

    function automatic logic [SAMPLE_W-1:0] frame_left(input logic [FRAME_W-1:0] frame);
        return frame[FRAME_W-1 -: SAMPLE_W];
    endfunction

    function automatic logic [SAMPLE_W-1:0] frame_right(input logic [FRAME_W-1:0] frame);
        return frame[SAMPLE_W-1:0];
    endfunction

endpackage

// File: rtl/audio_regs_pkg.sv
/* Register map of the audio peripheral. Offsets are byte addresses of
   32-bit words; only address bits 4:2 are decoded, so the map aliases. */
package audio_regs_pkg;

    // Register offsets
    localparam logic [4:0] ADDR_CTRL     = 5'd0;
    localparam logic [4:0] ADDR_STATUS   = 5'd4;
    localparam logic [4:0] ADDR_THRESH   = 5'd8;
    localparam logic [4:0] ADDR_SAMPLE_L = 5'd12;
    localparam logic [4:0] ADDR_SAMPLE_R = 5'd16;

    // Control bits
    localparam int CTRL_DAC_MODE = 0;
    localparam int CTRL_DAC_EN   = 1;
    localparam int CTRL_I2S_EN   = 2;
    // Self-clearing, always reads 0
    localparam int CTRL_SOFT_RST = 3;

    // Status flags
    localparam int STAT_FULL     = 0;
    localparam int STAT_EMPTY    = 1;
    localparam int STAT_LOW      = 2;
    // Sticky until STATUS is written
    localparam int STAT_OVERFLOW = 3;

    // FIFO fill level field
    localparam int STAT_LEVEL_LSB = 8;

endpackage

// File: rtl/clock_generator.sv
/* Strobes are one clk_i cycle wide and both counters restart on reset.
   Divide ratios of 1 give a strobe on every cycle. */
module clock_generator #(
    parameter int MCLK_DIV = 4,
    parameter int SCLK_DIV = 16
) (
    input  logic clk_i,
    input  logic reset_i,
    output logic mclk_stb_o,
    output logic sclk_stb_o
);

    localparam int MCLK_CNT_W = $clog2(MCLK_DIV + 1);
    localparam int SCLK_CNT_W = $clog2(SCLK_DIV + 1);

    logic [MCLK_CNT_W-1:0] mclk_cnt;
    logic [SCLK_CNT_W-1:0] sclk_cnt;

    // Strobe on the last count of each period
    assign mclk_stb_o = (mclk_cnt == MCLK_CNT_W'(MCLK_DIV - 1));
    assign sclk_stb_o = (sclk_cnt == SCLK_CNT_W'(SCLK_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mclk_cnt <= '0;
            sclk_cnt <= '0;
        end else begin
            if (mclk_stb_o) begin
                mclk_cnt <= '0;
            end else begin
                mclk_cnt <= mclk_cnt + 1'b1;
            end

            if (sclk_stb_o) begin
                sclk_cnt <= '0;
            end else begin
                sclk_cnt <= sclk_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/sample_fifo.sv
/* First-word fall-through FIFO of stereo frames, depth 2**FIFO_LEN_BITS.
   Writes while full and reads while empty are dropped silently. */
module sample_fifo #(
    parameter int FIFO_LEN_BITS = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          wr_i,
    input  logic [audio_pkg::FRAME_W-1:0] data_i,
    output logic                          full_o,
    input  logic                          rd_i,
    output logic [audio_pkg::FRAME_W-1:0] data_o,
    output logic                          empty_o,
    output logic [FIFO_LEN_BITS:0]        level_o
);

    import audio_pkg::*;

    localparam int DEPTH = 1 << FIFO_LEN_BITS;

    logic [FRAME_W-1:0]     mem [DEPTH];
    logic [FIFO_LEN_BITS:0] wr_ptr;
    logic [FIFO_LEN_BITS:0] rd_ptr;
    logic                   do_write;
    logic                   do_read;

    // Extra pointer bit tells a full buffer from an empty one
    assign level_o = wr_ptr - rd_ptr;
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (level_o == (FIFO_LEN_BITS + 1)'(DEPTH));

    assign do_write = wr_i && !full_o;
    assign do_read  = rd_i && !empty_o;

    // Head frame is visible without a read request
    assign data_o = mem[rd_ptr[FIFO_LEN_BITS-1:0]];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_LEN_BITS-1:0]] <= data_i;
        end
    end

endmodule

// File: rtl/i2s_master.sv
/* Standard I2S transmit only, one frame per 2*SLOT_BITS bit clocks.
   The bit clock has a short low phase of one clk_i cycle per strobe. */
module i2s_master (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,
    input  logic                          mclk_stb_i,
    input  logic                          sclk_stb_i,
    input  logic [audio_pkg::FRAME_W-1:0] frame_i,
    input  logic                          frame_valid_i,
    output logic                          pop_o,
    output logic                          i2s_mclk_o,
    output logic                          i2s_sclk_o,
    output logic                          i2s_lrclk_o,
    output logic                          i2s_sdata_o
);

    import audio_pkg::*;

    localparam int FRAME_BITS = 2 * SLOT_BITS;
    localparam int CNT_W      = $clog2(FRAME_BITS);
    localparam int PAD_W      = SLOT_BITS - SAMPLE_W;

    logic [CNT_W-1:0]      bit_cnt;
    logic [CNT_W-1:0]      next_cnt;
    logic                  frame_start;
    logic [FRAME_BITS-1:0] shift_q;
    logic [FRAME_BITS-1:0] load_bits;

    // Bit period index, wraps at the frame length
    assign next_cnt    = bit_cnt + 1'b1;
    assign frame_start = sclk_stb_i && (next_cnt == '0);

    // Only pop when a frame is really there
    assign pop_o = enable_i && frame_start && frame_valid_i;

    // Underrun sends a frame of zeros
    assign load_bits = frame_valid_i ?
        {frame_left(frame_i), {PAD_W{1'b0}}, frame_right(frame_i), {PAD_W{1'b0}}} : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i || !enable_i) begin
            // Start in a right slot so the first left slot opens on a word-clock edge
            bit_cnt     <= CNT_W'(SLOT_BITS - 1);
            shift_q     <= '0;
            i2s_mclk_o  <= 1'b0;
            i2s_sclk_o  <= 1'b0;
            i2s_lrclk_o <= 1'b0;
            i2s_sdata_o <= 1'b0;
        end else begin
            if (mclk_stb_i) begin
                i2s_mclk_o <= !i2s_mclk_o;
            end

            // Falling edge on the strobe, rising one cycle later
            i2s_sclk_o <= !sclk_stb_i;

            if (sclk_stb_i) begin
                bit_cnt     <= next_cnt;
                i2s_lrclk_o <= next_cnt[CNT_W-1];
                if (frame_start) begin
                    // Last bit of the right slot is always padding
                    i2s_sdata_o <= 1'b0;
                    shift_q     <= load_bits;
                end else begin
                    i2s_sdata_o <= shift_q[FRAME_BITS-1];
                    shift_q     <= {shift_q[FRAME_BITS-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: rtl/psoc_dac.sv
/* First-order sigma-delta per channel; outputs need external filtering.
   Holds the last sample when the FIFO runs dry. */
module psoc_dac #(
    parameter int SCLK_DIV = 16
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,
    input  logic [audio_pkg::FRAME_W-1:0] frame_i,
    input  logic                          frame_valid_i,
    output logic                          pop_o,
    output logic                          phone_l_o,
    output logic                          phone_r_o
);

    import audio_pkg::*;

    // Same frame rate as the I2S output
    localparam int PERIOD = 2 * SLOT_BITS * SCLK_DIV;
    localparam int CNT_W  = $clog2(PERIOD);

    logic [CNT_W-1:0]    frame_cnt;
    logic [SAMPLE_W-1:0] sample_l;
    logic [SAMPLE_W-1:0] sample_r;
    logic [SAMPLE_W-1:0] acc_l;
    logic [SAMPLE_W-1:0] acc_r;
    logic [SAMPLE_W:0]   sum_l;
    logic [SAMPLE_W:0]   sum_r;

    assign pop_o = enable_i && frame_valid_i && (frame_cnt == '0);

    // Inverting the sign bit gives offset binary; the carry is the output bit
    assign sum_l = {1'b0, acc_l} + {1'b0, ~sample_l[SAMPLE_W-1], sample_l[SAMPLE_W-2:0]};
    assign sum_r = {1'b0, acc_r} + {1'b0, ~sample_r[SAMPLE_W-1], sample_r[SAMPLE_W-2:0]};

    always_ff @(posedge clk_i) begin
        if (reset_i || !enable_i) begin
            frame_cnt <= '0;
            sample_l  <= '0;
            sample_r  <= '0;
            acc_l     <= '0;
            acc_r     <= '0;
            phone_l_o <= 1'b0;
            phone_r_o <= 1'b0;
        end else begin
            frame_cnt <= (frame_cnt == CNT_W'(PERIOD - 1)) ? '0 : frame_cnt + 1'b1;
            if (pop_o) begin
                sample_l <= frame_left(frame_i);
                sample_r <= frame_right(frame_i);
            end
            acc_l     <= sum_l[SAMPLE_W-1:0];
            acc_r     <= sum_r[SAMPLE_W-1:0];
            phone_l_o <= sum_l[SAMPLE_W];
            phone_r_o <= sum_r[SAMPLE_W];
        end
    end

endmodule

// File: rtl/audio_wb_regfile.sv
/* Wishbone classic single cycles only; wb_sel_i is ignored, so every write
   is a full word. Read data and ack come one cycle after the strobe. */
module audio_wb_regfile #(
    parameter int FIFO_LEN_BITS = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [31:0]                   wb_adr_i,
    // Byte lanes are not supported
    input  logic [3:0]                    wb_sel_i,
    input  logic [31:0]                   wb_dat_i,
    output logic [31:0]                   wb_dat_o,
    output logic                          wb_ack_o,
    output logic                          push_o,
    output logic [audio_pkg::FRAME_W-1:0] frame_o,
    input  logic                          fifo_full_i,
    input  logic                          fifo_empty_i,
    input  logic [FIFO_LEN_BITS:0]        fifo_level_i,
    output logic                          fifo_low_o,
    output logic                          dac_mode_o,
    output logic                          dac_enable_o,
    output logic                          i2s_enable_o,
    output logic                          soft_reset_o
);

    import audio_pkg::*;
    import audio_regs_pkg::*;

    logic                     req;
    logic                     wr_req;
    logic [4:0]               reg_addr;
    logic [CTRL_SOFT_RST-1:0] ctrl_q;
    logic                     soft_rst_q;
    logic [FIFO_LEN_BITS:0]   thresh_q;
    logic                     overflow_q;
    logic [SAMPLE_W-1:0]      left_q;
    logic [31:0]              status;
    logic [31:0]              rd_data;

    // New request only while ack is low
    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_req   = req && wb_we_i;
    assign reg_addr = {wb_adr_i[4:2], 2'b00};

    assign dac_mode_o   = ctrl_q[CTRL_DAC_MODE];
    assign dac_enable_o = ctrl_q[CTRL_DAC_EN];
    assign i2s_enable_o = ctrl_q[CTRL_I2S_EN];
    assign soft_reset_o = soft_rst_q;

    always_comb begin
        status                                    = '0;
        status[STAT_FULL]                         = fifo_full_i;
        status[STAT_EMPTY]                        = fifo_empty_i;
        status[STAT_LOW]                          = fifo_low_o;
        status[STAT_OVERFLOW]                     = overflow_q;
        status[STAT_LEVEL_LSB +: FIFO_LEN_BITS+1] = fifo_level_i;
    end

    // Sample registers are write-only
    always_comb begin
        case (reg_addr)
            ADDR_CTRL:   rd_data = 32'(ctrl_q);
            ADDR_STATUS: rd_data = status;
            ADDR_THRESH: rd_data = 32'(thresh_q);
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_o   <= 1'b0;
            ctrl_q     <= '0;
            soft_rst_q <= 1'b0;
            thresh_q   <= '0;
            overflow_q <= 1'b0;
            push_o     <= 1'b0;
            fifo_low_o <= 1'b0;
        end else begin
            wb_ack_o   <= req;
            soft_rst_q <= 1'b0;
            push_o     <= 1'b0;
            fifo_low_o <= (fifo_level_i < thresh_q);
            if (wr_req) begin
                case (reg_addr)
                    ADDR_CTRL: begin
                        ctrl_q     <= wb_dat_i[CTRL_SOFT_RST-1:0];
                        soft_rst_q <= wb_dat_i[CTRL_SOFT_RST];
                    end
                    ADDR_STATUS: overflow_q <= 1'b0;
                    ADDR_THRESH: thresh_q <= wb_dat_i[FIFO_LEN_BITS:0];
                    ADDR_SAMPLE_R: begin
                        // Full FIFO drops the frame
                        if (fifo_full_i) begin
                            overflow_q <= 1'b1;
                        end else begin
                            push_o <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
        if (wr_req && reg_addr == ADDR_SAMPLE_L) begin
            left_q <= wb_dat_i[SAMPLE_W-1:0];
        end
        if (wr_req && reg_addr == ADDR_SAMPLE_R) begin
            frame_o <= pack_frame(left_q, wb_dat_i[SAMPLE_W-1:0]);
        end
    end

endmodule

// File: rtl/psoc_audio.sv
/* Single clock domain; I2S clocks are divided register outputs of clk_i.
   Soft reset clears the datapath only, the registers keep their values. */
module psoc_audio #(
    parameter int FIFO_LEN_BITS = 8,
    parameter int MCLK_DIV      = 4,
    parameter int SCLK_DIV      = 16
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    // Level below threshold, usable as an interrupt
    output logic        fifo_low_o,
    output logic        i2s_mclk_o,
    output logic        i2s_sdata_o,
    output logic        i2s_sclk_o,
    output logic        i2s_lrclk_o,
    output logic        phone_l_o,
    output logic        phone_r_o
);

    import audio_pkg::*;

    logic [FRAME_W-1:0]     fifo_wr_data;
    logic [FRAME_W-1:0]     fifo_rd_data;
    logic                   fifo_wr;
    logic                   fifo_rd;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic [FIFO_LEN_BITS:0] fifo_level;
    logic                   mclk_stb;
    logic                   sclk_stb;
    logic                   i2s_pop;
    logic                   dac_pop;
    logic                   dac_mode;
    logic                   dac_enable;
    logic                   i2s_enable;
    logic                   soft_reset;
    logic                   dp_reset;

    assign dp_reset = reset_i || soft_reset;

    // Mode bit picks the FIFO reader
    assign fifo_rd = dac_mode ? dac_pop : i2s_pop;

    clock_generator #(
        .MCLK_DIV (MCLK_DIV),
        .SCLK_DIV (SCLK_DIV)
    ) u_clk_gen (
        .clk_i      (clk_i),
        .reset_i    (dp_reset),
        .mclk_stb_o (mclk_stb),
        .sclk_stb_o (sclk_stb)
    );

    sample_fifo #(
        .FIFO_LEN_BITS (FIFO_LEN_BITS)
    ) u_fifo (
        .clk_i   (clk_i),
        .reset_i (dp_reset),
        .wr_i    (fifo_wr),
        .data_i  (fifo_wr_data),
        .full_o  (fifo_full),
        .rd_i    (fifo_rd),
        .data_o  (fifo_rd_data),
        .empty_o (fifo_empty),
        .level_o (fifo_level)
    );

    // Each output only runs in its own mode
    i2s_master u_i2s (
        .clk_i         (clk_i),
        .reset_i       (dp_reset),
        .enable_i      (i2s_enable && !dac_mode),
        .mclk_stb_i    (mclk_stb),
        .sclk_stb_i    (sclk_stb),
        .frame_i       (fifo_rd_data),
        .frame_valid_i (!fifo_empty),
        .pop_o         (i2s_pop),
        .i2s_mclk_o    (i2s_mclk_o),
        .i2s_sclk_o    (i2s_sclk_o),
        .i2s_lrclk_o   (i2s_lrclk_o),
        .i2s_sdata_o   (i2s_sdata_o)
    );

    psoc_dac #(
        .SCLK_DIV (SCLK_DIV)
    ) u_dac (
        .clk_i         (clk_i),
        .reset_i       (dp_reset),
        .enable_i      (dac_enable && dac_mode),
        .frame_i       (fifo_rd_data),
        .frame_valid_i (!fifo_empty),
        .pop_o         (dac_pop),
        .phone_l_o     (phone_l_o),
        .phone_r_o     (phone_r_o)
    );

    audio_wb_regfile #(
        .FIFO_LEN_BITS (FIFO_LEN_BITS)
    ) u_regs (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .push_o       (fifo_wr),
        .frame_o      (fifo_wr_data),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .fifo_level_i (fifo_level),
        .fifo_low_o   (fifo_low_o),
        .dac_mode_o   (dac_mode),
        .dac_enable_o (dac_enable),
        .i2s_enable_o (i2s_enable),
        .soft_reset_o (soft_reset)
    );

endmodule

// File: test/tb_psoc_audio.sv
/* Runs with a 4-frame FIFO and short I2S frames (SCLK_DIV 4).
   Expected frames come from a queue model of the FIFO. */
module tb_psoc_audio;

    timeunit 1ns;
    timeprecision 1ps;

    import audio_regs_pkg::*;

    localparam int FIFO_LEN_BITS = 2;
    localparam int DEPTH         = 1 << FIFO_LEN_BITS;
    localparam int SCLK_DIV      = 4;
    localparam int FRAME_CYC     = 64 * SCLK_DIV;
    localparam int I2S_FRAMES    = 3;
    localparam int TOTAL_FRAMES  = 16;
    localparam int WATCHDOG_NS   = (TOTAL_FRAMES * FRAME_CYC + 4000) * 100;
    localparam int DAC_PERIODS   = 2;

    logic        clk_i;
    logic        reset_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        fifo_low_o;
    logic        i2s_mclk_o;
    logic        i2s_sdata_o;
    logic        i2s_sclk_o;
    logic        i2s_lrclk_o;
    logic        phone_l_o;
    logic        phone_r_o;

    int          errors;
    int          frames_seen;
    int          status_reads;
    logic [30:0] lcg_state;
    logic [47:0] exp_q[$];
    logic        ovf_exp;
    logic [31:0] rd;
    logic        i2s_on;
    logic        dac_on;

    // Deserializer state
    logic        sclk_q;
    logic        lr_q;
    logic        in_frame;
    logic        have_left;
    int          bit_idx;
    logic [23:0] shift_r;
    logic [23:0] left_word;

    psoc_audio #(
        .FIFO_LEN_BITS (FIFO_LEN_BITS),
        .MCLK_DIV      (4),
        .SCLK_DIV      (SCLK_DIV)
    ) u_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .fifo_low_o  (fifo_low_o),
        .i2s_mclk_o  (i2s_mclk_o),
        .i2s_sdata_o (i2s_sdata_o),
        .i2s_sclk_o  (i2s_sclk_o),
        .i2s_lrclk_o (i2s_lrclk_o),
        .phone_l_o   (phone_l_o),
        .phone_r_o   (phone_r_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic note_error(input string msg);
        errors++;
        $display("FAIL @%0t: %s", $time, msg);
    endtask

    // Strobe gets ack on the next cycle for one cycle only
    ack_follows_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
        else note_error("ack did not follow strobe");
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else note_error("ack longer than one cycle");
    i2s_quiet_in_dac: assert property (@(posedge clk_i) disable iff (reset_i)
        dac_on |-> !(i2s_mclk_o || i2s_sclk_o || i2s_lrclk_o || i2s_sdata_o))
        else note_error("I2S outputs active in DAC mode");

    function automatic logic [23:0] next_rand();
        lcg_state = lcg_state * 31'd1103515245 + 31'd12345;
        return lcg_state[30:7];
    endfunction

    function automatic longint dac_ones(input logic [23:0] s, input int cycles);
        longint off;
        off = longint'($signed(s)) + 64'sd8388608;
        return off * cycles / 64'sd16777216;
    endfunction

    task automatic bus_cycle(input logic we, input logic [4:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= 32'(addr);
        wb_dat_i <= data;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!wb_ack_o && waited < 10);
        if (!wb_ack_o) begin
            errors++;
            $display("Bus cycle to 0x%0h got no ack", addr);
        end
        rdata = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic push_pair(input logic [23:0] left, input logic [23:0] right);
        bus_write(ADDR_SAMPLE_L, 32'(left));
        bus_write(ADDR_SAMPLE_R, 32'(right));
        if (exp_q.size() < DEPTH) begin
            exp_q.push_back({left, right});
        end else begin
            ovf_exp = 1'b1;
        end
    endtask

    task automatic check_status(input int thresh);
        int lvl;
        bus_cycle(1'b0, ADDR_STATUS, 32'd0, rd);
        status_reads++;
        lvl = exp_q.size();
        assert (rd[STAT_LEVEL_LSB +: FIFO_LEN_BITS+1] == lvl)
            else note_error($sformatf("level %0d, expected %0d",
                rd[STAT_LEVEL_LSB +: FIFO_LEN_BITS+1], lvl));
        assert (rd[STAT_EMPTY] == (lvl == 0) && rd[STAT_FULL] == (lvl == DEPTH))
            else note_error("empty or full flag wrong");
        assert (rd[STAT_OVERFLOW] == ovf_exp)
            else note_error("overflow flag wrong");
        assert (fifo_low_o == (lvl < thresh) && rd[STAT_LOW] == (lvl < thresh))
            else note_error("low flag does not match level below threshold");
    endtask

    // I2S deserializer that watches the bit clock from the clk_i domain
    always @(posedge clk_i) begin
        sclk_q <= i2s_sclk_o;
        if (!i2s_on) begin
            in_frame  = 1'b0;
            have_left = 1'b0;
            lr_q      = 1'b0;
            bit_idx   = 0;
        end else if (i2s_sclk_o && !sclk_q) begin
            if (i2s_lrclk_o != lr_q) begin
                bit_idx = 0;
                if (!i2s_lrclk_o) begin
                    if (have_left) begin
                        check_frame({left_word, shift_r});
                    end
                    in_frame  = 1'b1;
                    have_left = 1'b0;
                end else if (in_frame) begin
                    left_word = shift_r;
                    have_left = 1'b1;
                end
                shift_r = '0;
            end else begin
                bit_idx++;
            end
            // MSB comes one bit after the word-clock edge
            if (bit_idx >= 1 && bit_idx <= 24) begin
                shift_r = {shift_r[22:0], i2s_sdata_o};
            end
            lr_q = i2s_lrclk_o;
        end
    end

    task automatic check_frame(input logic [47:0] got);
        logic [47:0] want;
        want = (exp_q.size() > 0) ? exp_q.pop_front() : 48'd0;
        frames_seen++;
        assert (got == want)
            else note_error($sformatf("I2S frame %h, expected %h", got, want));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [23:0] dac_l;
        logic [23:0] dac_r;
        longint      ones_l;
        longint      ones_r;
        longint      want_l;
        longint      want_r;
        int          waited;

        clk_i = 1'b0;
        reset_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = 4'hf;
        wb_dat_i = '0;
        errors = 0;
        frames_seen = 0;
        status_reads = 0;
        lcg_state = 31'd28771;
        ovf_exp = 1'b0;
        i2s_on = 1'b0;
        dac_on = 1'b0;
        sclk_q = 1'b0;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        assert (!wb_ack_o && !fifo_low_o && !i2s_mclk_o && !i2s_sclk_o && !i2s_lrclk_o
                && !i2s_sdata_o && !phone_l_o && !phone_r_o)
            else note_error("outputs not 0 after reset");

        // Register readback where the soft-reset bit reads 0
        bus_write(ADDR_THRESH, 32'd3);
        bus_cycle(1'b0, ADDR_THRESH, 32'd0, rd);
        assert (rd == 32'd3) else note_error("THRESH readback wrong");
        bus_write(ADDR_CTRL, 32'hb);
        bus_cycle(1'b0, ADDR_CTRL, 32'd0, rd);
        assert (rd == 32'h3) else note_error("CTRL readback wrong");
        bus_write(ADDR_CTRL, 32'h0);

        // Status and overflow
        push_pair(next_rand(), next_rand());
        push_pair(next_rand(), next_rand());
        check_status(3);
        push_pair(next_rand(), next_rand());
        push_pair(next_rand(), next_rand());
        check_status(3);
        push_pair(next_rand(), next_rand());
        check_status(3);
        bus_write(ADDR_STATUS, 32'd0);
        ovf_exp = 1'b0;
        check_status(3);

        // Soft reset while the DAC runs keeps the mode bits and empties the FIFO
        bus_write(ADDR_CTRL, 32'h3);
        bus_write(ADDR_CTRL, 32'hb);
        @(posedge clk_i);
        assert (!i2s_mclk_o && !i2s_sclk_o && !i2s_lrclk_o && !i2s_sdata_o
                && !phone_l_o && !phone_r_o)
            else note_error("outputs not 0 after soft reset");
        exp_q.delete();
        check_status(3);
        bus_cycle(1'b0, ADDR_CTRL, 32'd0, rd);
        assert (rd == 32'h3) else note_error("CTRL lost mode bits on soft reset");
        bus_write(ADDR_CTRL, 32'h0);

        // I2S frames followed by underrun zeros
        repeat (I2S_FRAMES) push_pair(next_rand(), next_rand());
        i2s_on = 1'b1;
        bus_write(ADDR_CTRL, 32'h4);
        waited = 0;
        while (frames_seen < I2S_FRAMES + 2 && waited < 8 * FRAME_CYC) begin
            @(posedge clk_i);
            waited++;
        end
        if (frames_seen < I2S_FRAMES + 2) begin
            errors++;
            $display("Only %0d I2S frames recovered", frames_seen);
        end
        bus_write(ADDR_CTRL, 32'h0);
        i2s_on = 1'b0;

        // DAC density with constant samples
        dac_l = 24'h400000;
        dac_r = 24'he00000;
        repeat (DEPTH) push_pair(dac_l, dac_r);
        // I2S enable stays set so the DAC mode bit alone must keep I2S quiet
        bus_write(ADDR_CTRL, 32'h7);
        repeat (2) @(posedge clk_i);
        dac_on = 1'b1;
        repeat (10) @(posedge clk_i);
        ones_l = 0;
        ones_r = 0;
        repeat (DAC_PERIODS * FRAME_CYC) begin
            @(posedge clk_i);
            ones_l += phone_l_o;
            ones_r += phone_r_o;
        end
        want_l = dac_ones(dac_l, DAC_PERIODS * FRAME_CYC);
        want_r = dac_ones(dac_r, DAC_PERIODS * FRAME_CYC);
        assert (ones_l >= want_l - DAC_PERIODS && ones_l <= want_l + DAC_PERIODS)
            else note_error($sformatf("left density %0d, expected %0d", ones_l, want_l));
        assert (ones_r >= want_r - DAC_PERIODS && ones_r <= want_r + DAC_PERIODS)
            else note_error($sformatf("right density %0d, expected %0d", ones_r, want_r));
        dac_on = 1'b0;

        $display("Done: %0d errors, %0d I2S frames, %0d status reads",
                 errors, frames_seen, status_reads);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: psoc_audio.f
rtl/audio_pkg.sv
rtl/audio_regs_pkg.sv
rtl/clock_generator.sv
rtl/sample_fifo.sv
rtl/i2s_master.sv
rtl/psoc_dac.sv
rtl/audio_wb_regfile.sv
rtl/psoc_audio.sv
test/tb_psoc_audio.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= psoc_audio.f
TB_TOP    ?= tb_psoc_audio
RTL_TOP   ?= psoc_audio
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

RTL_FILES = $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
